//--- source/div_pkg.sv
//////////////////////////////
// Shared widths, operation encoding and queued-operation types
// for the divider, referenced by scoped names
//////////////////////////////

package div_pkg;

    // Default widths; the top level passes its own values down
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int ID_WIDTH       = 3;
    localparam int CLZ_WIDTH      = $clog2(DATA_WIDTH);

    // Bit 1 selects remainder, bit 0 selects unsigned
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_t;

    // Attributes that follow an operation to writeback
    typedef struct packed {
        logic                remainder_op;
        logic                negate_result;
        logic                divisor_is_zero;
        logic                reuse_result;
        logic [ID_WIDTH-1:0] id;
    } div_attr_t;

    // One entry of the input slot
    typedef struct packed {
        logic [DATA_WIDTH-1:0] unsigned_dividend;
        logic [DATA_WIDTH-1:0] unsigned_divisor;
        logic [CLZ_WIDTH-1:0]  dividend_clz;
        logic [CLZ_WIDTH-1:0]  divisor_clz;
        div_attr_t             attr;
    } div_queued_t;

    // Two's complement negate when asked, pass-through otherwise
    function automatic logic [DATA_WIDTH-1:0] negate_if(input logic [DATA_WIDTH-1:0] value,
                                                        input logic negate);
        return ({DATA_WIDTH{negate}} ^ value) + DATA_WIDTH'(negate);
    endfunction

endpackage

//--- source/div_interfaces.sv
//////////////////////////////
// Issue and writeback handshakes between the core and the divider
//////////////////////////////
`timescale 1ns/1ps

// Operands and tag from the core; ready back from the unit
interface div_issue_if #(
    parameter int DATA_WIDTH = div_pkg::DATA_WIDTH,
    parameter int ID_WIDTH   = div_pkg::ID_WIDTH
);
    logic                              new_request;
    logic                              ready;
    logic [div_pkg::REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [div_pkg::REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [div_pkg::REG_ADDR_WIDTH-1:0] rd_addr;
    logic [DATA_WIDTH-1:0]             rs1_data;
    logic [DATA_WIDTH-1:0]             rs2_data;
    div_pkg::div_op_t                  op;
    logic [ID_WIDTH-1:0]               id;

    modport unit (
        input  new_request, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, op, id,
        output ready
    );

    modport core (
        output new_request, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, op, id,
        input  ready
    );
endinterface

// Result and tag held by the unit until the core acknowledges
interface div_wb_if #(
    parameter int DATA_WIDTH = div_pkg::DATA_WIDTH,
    parameter int ID_WIDTH   = div_pkg::ID_WIDTH
);
    logic                  done;
    logic                  ack;
    logic [DATA_WIDTH-1:0] result;
    logic [ID_WIDTH-1:0]   id;

    modport unit (
        output done, result, id,
        input  ack
    );

    modport core (
        input  done, result, id,
        output ack
    );
endinterface

//--- source/div_operand_prep.sv
//////////////////////////////
// Combinational operand preparation: magnitudes, leading zeros and signs
//////////////////////////////
`timescale 1ns/1ps

module div_operand_prep #(
    parameter int DATA_WIDTH = div_pkg::DATA_WIDTH
) (
    div_issue_if.unit            issue,
    output div_pkg::div_queued_t queued
);

    localparam int CLZ_WIDTH = $clog2(DATA_WIDTH);

    logic                  signed_op;
    logic                  dividend_neg;
    logic                  divisor_neg;
    logic                  divisor_is_zero;
    logic [DATA_WIDTH-1:0] dividend_mag;
    logic [DATA_WIDTH-1:0] divisor_mag;
    logic [CLZ_WIDTH-1:0]  dividend_clz;
    logic [CLZ_WIDTH-1:0]  divisor_clz;

    // Highest set bit wins; a zero value saturates at all ones
    function automatic logic [CLZ_WIDTH-1:0] count_lz(input logic [DATA_WIDTH-1:0] value);
        logic [CLZ_WIDTH-1:0] count;
        count = '1;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (value[i]) begin
                count = CLZ_WIDTH'(DATA_WIDTH - 1 - i);
            end
        end
        return count;
    endfunction

    //////////////////////////////
    // Signs
    //////////////////////////////
    assign signed_op    = ~issue.op[0];
    assign dividend_neg = signed_op & issue.rs1_data[DATA_WIDTH-1];
    assign divisor_neg  = signed_op & issue.rs2_data[DATA_WIDTH-1];

    //////////////////////////////
    // Magnitudes and counts
    //////////////////////////////
    assign dividend_mag    = div_pkg::negate_if(issue.rs1_data, dividend_neg);
    assign divisor_mag     = div_pkg::negate_if(issue.rs2_data, divisor_neg);
    assign dividend_clz    = count_lz(dividend_mag);
    assign divisor_clz     = count_lz(divisor_mag);
    assign divisor_is_zero = ~|issue.rs2_data;

    always_comb begin
        queued.unsigned_dividend = dividend_mag;
        queued.unsigned_divisor  = divisor_mag;
        // Zero divisor runs the full width so the quotient fills with ones
        queued.dividend_clz      = divisor_is_zero ? '0 : dividend_clz;
        queued.divisor_clz       = divisor_clz;

        queued.attr.remainder_op    = issue.op[1];
        queued.attr.divisor_is_zero = divisor_is_zero;
        // Remainder takes the dividend sign, quotient the sign difference
        if (issue.op[1]) begin
            queued.attr.negate_result = dividend_neg;
        end else begin
            queued.attr.negate_result = (dividend_neg ^ divisor_neg) & ~divisor_is_zero;
        end
        // Reuse is decided by the control block when the slot loads
        queued.attr.reuse_result = 1'b0;
        queued.attr.id           = issue.id;
    end

endmodule

//--- source/div_control.sv
//////////////////////////////
// Input slot, in-progress FSM, result reuse and writeback done/ack
//////////////////////////////
`timescale 1ns/1ps

module div_control (
    input  logic                                clk,
    input  logic                                rst,
    div_issue_if.unit                           issue,
    div_wb_if.unit                              wb,
    input  div_pkg::div_queued_t                prepared,
    input  logic                                rd_issued,
    input  logic [div_pkg::REG_ADDR_WIDTH-1:0]  rd_issued_addr,
    input  logic                                flush,
    output logic                                start,
    output div_pkg::div_queued_t                current,
    input  logic                                core_done,
    output div_pkg::div_attr_t                  result_attr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_QUEUED,
        ST_DIVIDING,
        ST_HOLDING
    } state_t;

    state_t                             state;
    state_t                             state_next;
    logic                               slot_valid;
    logic                               in_progress;
    logic                               pop;
    logic                               reuse_valid;
    logic                               reuse_hit;
    logic                               own_source;
    logic                               source_rewritten;
    logic                               prev_unsigned;
    logic [div_pkg::REG_ADDR_WIDTH-1:0] prev_rs1;
    logic [div_pkg::REG_ADDR_WIDTH-1:0] prev_rs2;

    //////////////////////////////
    // Result reuse tracking
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (issue.new_request) begin
            prev_rs1      <= issue.rs1_addr;
            prev_rs2      <= issue.rs2_addr;
            prev_unsigned <= issue.op[0]; 
        end
    end

    // Same sources and signedness as the last divide
    assign reuse_hit = reuse_valid && (prev_rs1 == issue.rs1_addr)
                       && (prev_rs2 == issue.rs2_addr) && (prev_unsigned == issue.op[0]);
    assign own_source = (issue.rd_addr == issue.rs1_addr) || (issue.rd_addr == issue.rs2_addr);
    assign source_rewritten = rd_issued
                              && ((rd_issued_addr == prev_rs1) || (rd_issued_addr == prev_rs2));

    // A new divide decides the flag ahead of any clear
    // Overwriting its own source leaves nothing to reuse
    always_ff @(posedge clk) begin
        if (rst) begin
            reuse_valid <= 1'b0;
        end else if (issue.new_request) begin
            reuse_valid <= !own_source;
        end else if (flush || source_rewritten) begin
            reuse_valid <= 1'b0;
        end
    end

    //////////////////////////////
    // Input slot
    //////////////////////////////
    assign in_progress = (state == ST_DIVIDING) || (state == ST_HOLDING);
    assign pop         = slot_valid && (!in_progress || wb.ack);
    assign issue.ready = !slot_valid || !in_progress;
    assign start       = pop && !current.attr.reuse_result;

    always_ff @(posedge clk) begin
        if (issue.new_request) begin
            current                   <= prepared;
            current.attr.reuse_result <= reuse_hit;
        end
        if (pop) begin
            result_attr <= current.attr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= issue.new_request || (slot_valid && !pop);
        end
    end

    //////////////////////////////
    // FSM
    //////////////////////////////
    always_comb begin
        state_next = state;
        if (pop) begin
            // Reuse and zero-iteration ops complete without dividing
            if (current.attr.reuse_result || core_done) begin
                state_next = ST_HOLDING;
            end else begin
                state_next = ST_DIVIDING;
            end
        end else begin
            case (state)
                ST_IDLE:     if (issue.new_request) state_next = ST_QUEUED;
                ST_DIVIDING: if (core_done) state_next = ST_HOLDING;
                ST_HOLDING:  if (wb.ack) state_next = issue.new_request ? ST_QUEUED : ST_IDLE;
                default:     state_next = state;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Done holds until ack, and rises again if the next result lands then
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.done <= 1'b0;
        end else begin
            wb.done <= (wb.done && !wb.ack) || core_done || (pop && current.attr.reuse_result);
        end
    end

    assign wb.id = result_attr.id;

    //////////////////////////////
    // Assertions
    //////////////////////////////
    a_request_needs_ready: assert property (@(posedge clk) disable iff (rst)
        issue.new_request |-> issue.ready);

    // The datapath result must not move while it waits for ack
    a_done_held: assert property (@(posedge clk) disable iff (rst)
        wb.done && !wb.ack |=> wb.done && $stable(wb.id) && $stable(wb.result));

endmodule

//--- source/div_iter_counter.sv
//////////////////////////////
// Iteration counter; last marks the final shift-subtract step
//////////////////////////////
`timescale 1ns/1ps

module div_iter_counter #(
    parameter int DATA_WIDTH = div_pkg::DATA_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [$clog2(DATA_WIDTH)-1:0] dividend_clz,
    input  logic [$clog2(DATA_WIDTH)-1:0] divisor_clz,
    output logic                          last,
    output logic                          busy
);

    logic [$clog2(DATA_WIDTH)-1:0] count;
    logic                          has_steps;

    // Divisor larger than dividend means no quotient bits at all
    assign has_steps = divisor_clz >= dividend_clz;
    assign last      = (busy && (count == '0)) || (start && !has_steps);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= has_steps;
        end else if (last) begin
            busy <= 1'b0;
        end
    end

    // Remaining steps after the current one
    always_ff @(posedge clk) begin
        if (start) begin
            count <= divisor_clz - dividend_clz;
        end else if (busy && !last) begin
            count <= count - 1'b1;
        end
    end

    // A wrap would show as the count jumping up mid-division
    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        busy && !start |=> !busy || (count < $past(count)));

endmodule

//--- source/div_datapath.sv
//////////////////////////////
// Shift-subtract core with kept quotient/remainder and sign fix-up
//////////////////////////////
`timescale 1ns/1ps

module div_datapath #(
    parameter int DATA_WIDTH = div_pkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  div_pkg::div_queued_t  operands,
    input  logic                  busy,
    input  logic                  last,
    input  div_pkg::div_attr_t    attr,
    output logic [DATA_WIDTH-1:0] result
);

    localparam int CLZ_WIDTH = $clog2(DATA_WIDTH);

    logic [DATA_WIDTH-1:0] rem_work;
    logic [DATA_WIDTH-1:0] quo_work;
    logic [DATA_WIDTH-1:0] div_work;
    logic [DATA_WIDTH-1:0] rem_next;
    logic [DATA_WIDTH-1:0] quo_next;
    logic [DATA_WIDTH:0]   diff;
    logic [CLZ_WIDTH-1:0]  shift;
    logic [DATA_WIDTH-1:0] quotient;
    logic [DATA_WIDTH-1:0] remainder;
    logic [DATA_WIDTH-1:0] selected;

    //////////////////////////////
    // One compare-subtract per busy cycle
    //////////////////////////////
    assign shift    = operands.divisor_clz - operands.dividend_clz;
    assign diff     = {1'b0, rem_work} - {1'b0, div_work};
    assign rem_next = diff[DATA_WIDTH] ? rem_work : diff[DATA_WIDTH-1:0];
    assign quo_next = {quo_work[DATA_WIDTH-2:0], ~diff[DATA_WIDTH]};

    always_ff @(posedge clk) begin
        if (start) begin
            // Line the divisor MSB up with the dividend MSB
            rem_work <= operands.unsigned_dividend;
            div_work <= operands.unsigned_divisor << shift;
            quo_work <= '0;
        end else if (busy) begin
            rem_work <= rem_next;
            quo_work <= quo_next;
            div_work <= div_work >> 1;
        end
    end

    // Final pair stays put so a following reuse picks the other half
    always_ff @(posedge clk) begin
        if (last) begin
            if (busy) begin
                quotient  <= quo_next;
                remainder <= rem_next;
            end else begin
                quotient  <= '0;
                remainder <= operands.unsigned_dividend;
            end
        end
    end

    //////////////////////////////
    // Result selection
    //////////////////////////////
    always_comb begin
        if (attr.remainder_op) begin
            selected = remainder;
        end else if (attr.divisor_is_zero) begin
            selected = '1;
        end else begin
            selected = quotient;
        end
        result = div_pkg::negate_if(selected, attr.negate_result);
    end

    // Control must not start while the counter still runs
    a_start_when_free: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

//--- source/div_unit_top.sv
//////////////////////////////
// Divider top level; flat issue_/wb_ ports onto internal interfaces
//////////////////////////////
`timescale 1ns/1ps

module div_unit_top #(
    parameter int DATA_WIDTH = div_pkg::DATA_WIDTH,
    parameter int ID_WIDTH   = div_pkg::ID_WIDTH
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               issue_new_request,
    output logic                               issue_ready,
    input  div_pkg::div_op_t                   issue_op,
    input  logic [ID_WIDTH-1:0]                issue_id,
    input  logic [div_pkg::REG_ADDR_WIDTH-1:0] issue_rs1_addr,
    input  logic [div_pkg::REG_ADDR_WIDTH-1:0] issue_rs2_addr,
    input  logic [div_pkg::REG_ADDR_WIDTH-1:0] issue_rd_addr,
    input  logic [DATA_WIDTH-1:0]              issue_rs1_data,
    input  logic [DATA_WIDTH-1:0]              issue_rs2_data,
    input  logic                               rd_issued,
    input  logic [div_pkg::REG_ADDR_WIDTH-1:0] rd_issued_addr,
    input  logic                               flush,
    output logic                               wb_done,
    input  logic                               wb_ack,
    output logic [DATA_WIDTH-1:0]              wb_result,
    output logic [ID_WIDTH-1:0]                wb_id
);

    div_pkg::div_queued_t prepared;
    div_pkg::div_queued_t current;
    div_pkg::div_attr_t   result_attr;
    logic                 start;
    logic                 last;
    logic                 busy;

    div_issue_if #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) issue_if ();
    div_wb_if    #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) wb_if ();

    // Flat ports onto the interfaces
    assign issue_if.new_request = issue_new_request;
    assign issue_if.op          = issue_op;
    assign issue_if.id          = issue_id;
    assign issue_if.rs1_addr    = issue_rs1_addr;
    assign issue_if.rs2_addr    = issue_rs2_addr;
    assign issue_if.rd_addr     = issue_rd_addr;
    assign issue_if.rs1_data    = issue_rs1_data;
    assign issue_if.rs2_data    = issue_rs2_data;
    assign issue_ready          = issue_if.ready;
    assign wb_if.ack            = wb_ack;
    assign wb_done              = wb_if.done;
    assign wb_result            = wb_if.result;
    assign wb_id                = wb_if.id;

    div_operand_prep #(.DATA_WIDTH(DATA_WIDTH)) i_div_operand_prep (
        .issue  (issue_if.unit),
        .queued (prepared)
    );

    div_control i_div_control (
        .clk            (clk),
        .rst            (rst),
        .issue          (issue_if.unit),
        .wb             (wb_if.unit),
        .prepared       (prepared),
        .rd_issued      (rd_issued),
        .rd_issued_addr (rd_issued_addr),
        .flush          (flush),
        .start          (start),
        .current        (current),
        .core_done      (last),
        .result_attr    (result_attr)
    );

    div_iter_counter #(.DATA_WIDTH(DATA_WIDTH)) i_div_iter_counter (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .dividend_clz (current.dividend_clz),
        .divisor_clz  (current.divisor_clz),
        .last         (last),
        .busy         (busy)
    );

    div_datapath #(.DATA_WIDTH(DATA_WIDTH)) i_div_datapath (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .operands (current),
        .busy     (busy),
        .last     (last),
        .attr     (result_attr),
        .result   (wb_if.result)
    );

endmodule

//--- sim/div_checker.sv
//////////////////////////////
// Writeback monitor; compares each result with the queued expectation
//////////////////////////////
`timescale 1ns/1ps

module div_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_ready,
    input  logic             exp_push,
    input  div_pkg::div_op_t exp_op,
    input  logic [2:0]       exp_id,
    input  logic [31:0]      exp_result,
    input  logic             wb_done,
    input  logic             wb_ack,
    input  logic [31:0]      wb_result,
    input  logic [2:0]       wb_id,
    output int               checked_count,
    output int               error_count
);

    // Entry is {op, id, result}, in issue order
    logic [36:0] expected_q [$];
    logic [36:0] entry;
    logic        prev_hold;
    logic [31:0] prev_result;
    logic [2:0]  prev_id;
    string       test_name;

    function automatic string op_name(input logic [1:0] op);
        case (op)
            2'b00:   return "DIV";
            2'b01:   return "DIVU";
            2'b10:   return "REM";
            default: return "REMU";
        endcase
    endfunction

    initial begin
        checked_count = 0;
        error_count   = 0;
        prev_hold     = 1'b0;
        prev_result   = '0;
        prev_id       = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            prev_hold = 1'b0;
        end else begin
            // Held writeback must not move before ack
            if (prev_hold && (!wb_done || wb_result !== prev_result || wb_id !== prev_id)) begin
                $display("Writeback changed before ack: done %b id %0d result %h",
                         wb_done, wb_id, wb_result);
                error_count = error_count + 1;
            end
            // Ready only drops with one dividing and one waiting
            if (!issue_ready && expected_q.size() < 2) begin
                $display("Ready was low with only %0d operations held", expected_q.size());
                error_count = error_count + 1;
            end
            if (wb_done && wb_ack) begin
                if (expected_q.size() == 0) begin
                    $display("Writeback of id %0d arrived with no operation outstanding", wb_id);
                    error_count = error_count + 1;
                end else begin
                    entry     = expected_q.pop_front();
                    test_name = $sformatf("%s test %0d", op_name(entry[36:35]), checked_count);
                    if (wb_result !== entry[31:0] || wb_id !== entry[34:32]) begin
                        $display("FAILED %s: expected %h id %0d, actual %h id %0d",
                                 test_name, entry[31:0], entry[34:32], wb_result, wb_id);
                        error_count = error_count + 1;
                    end else begin
                        $display("ok     %s: id %0d result %h", test_name, wb_id, wb_result);
                    end
                    checked_count = checked_count + 1;
                end
            end
            if (exp_push) begin
                expected_q.push_back({exp_op, exp_id, exp_result});
            end
            prev_hold   = wb_done && !wb_ack;
            prev_result = wb_result;
            prev_id     = wb_id;
        end
    end

endmodule

//--- sim/div_tb.sv
//////////////////////////////
// Testbench for the divider with random and directed divides,
// register file model, random ack delays and a cycle timeout
//////////////////////////////
`timescale 1ns/1ps

module div_tb;

    localparam int          DATA_WIDTH     = 32;
    localparam int          ID_WIDTH       = 3;
    localparam int          NUM_DIRECTED   = 16;
    localparam int          NUM_RANDOM     = 200;
    localparam int          NUM_TESTS      = NUM_DIRECTED + NUM_RANDOM;
    localparam int          TIMEOUT_CYCLES = NUM_TESTS * 40 + 100;
    localparam logic [31:0] SEED           = 32'h46144873;

    logic                               clk;
    logic                               rst;
    logic                               issue_new_request;
    logic                               issue_ready;
    div_pkg::div_op_t                   issue_op;
    logic [ID_WIDTH-1:0]                issue_id;
    logic [div_pkg::REG_ADDR_WIDTH-1:0] issue_rs1_addr;
    logic [div_pkg::REG_ADDR_WIDTH-1:0] issue_rs2_addr;
    logic [div_pkg::REG_ADDR_WIDTH-1:0] issue_rd_addr;
    logic [DATA_WIDTH-1:0]              issue_rs1_data;
    logic [DATA_WIDTH-1:0]              issue_rs2_data;
    logic                               rd_issued;
    logic [div_pkg::REG_ADDR_WIDTH-1:0] rd_issued_addr;
    logic                               flush;
    logic                               wb_done;
    logic                               wb_ack;
    logic [DATA_WIDTH-1:0]              wb_result;
    logic [ID_WIDTH-1:0]                wb_id;

    // Expected results handed to the checker
    logic                  exp_push;
    div_pkg::div_op_t      exp_op;
    logic [ID_WIDTH-1:0]   exp_id;
    logic [DATA_WIDTH-1:0] exp_result;
    int                    checked_count;
    int                    error_count;

    logic [DATA_WIDTH-1:0] regs [8];
    logic [31:0]           rand_state;
    logic [31:0]           ack_state;
    logic [ID_WIDTH-1:0]   next_id;
    int                    issued_count;
    int                    cycle_count;

    div_unit_top #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) i_div_unit_top (.*);

    div_checker i_div_checker (
        .clk           (clk),
        .rst           (rst),
        .issue_ready   (issue_ready),
        .exp_push      (exp_push),
        .exp_op        (exp_op),
        .exp_id        (exp_id),
        .exp_result    (exp_result),
        .wb_done       (wb_done),
        .wb_ack        (wb_ack),
        .wb_result     (wb_result),
        .wb_id         (wb_id),
        .checked_count (checked_count),
        .error_count   (error_count)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // RISC-V divide rules around the language's own signed division
    function automatic logic [31:0] model_result(input div_pkg::div_op_t op,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic               overflow;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        sa = a;
        sb = b;
        sq = '0;
        sr = '0;
        if (b != 32'h0 && !overflow) begin
            sq = sa / sb;
            sr = sa % sb;
        end
        case (op)
            div_pkg::OP_DIV:  return (b == 0) ? 32'hFFFF_FFFF : (overflow ? a : sq);
            div_pkg::OP_DIVU: return (b == 0) ? 32'hFFFF_FFFF : a / b;
            div_pkg::OP_REM:  return (b == 0) ? a : (overflow ? 32'h0 : sr);
            default:          return (b == 0) ? a : a % b;
        endcase
    endfunction

    task automatic draw(output logic [31:0] value);
        rand_state = lcg_step(rand_state);
        value = rand_state;
    endtask

    // Mix of edge values, small values and full-width words
    task automatic random_value(output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        draw(a);
        draw(b);
        case (a[30:28])
            3'd0:    value = 32'h0;
            3'd1:    value = 32'hFFFF_FFFF;
            3'd2:    value = 32'h8000_0000;
            3'd3:    value = {24'h0, b[31:24]};
            3'd4:    value = -{24'h0, b[31:24]};
            3'd5:    value = b >> a[20:16];
            default: value = b;
        endcase
    endtask

    // Advance to just after the next edge and drop all pulses
    task automatic next_cycle();
        @(posedge clk);
        #1;
        issue_new_request = 1'b0;
        rd_issued         = 1'b0;
        flush             = 1'b0;
        exp_push          = 1'b0;
    endtask

    // Some other instruction writes a register
    task automatic write_reg(input logic [2:0] addr, input logic [31:0] value);
        rd_issued      = 1'b1;
        rd_issued_addr = {2'b00, addr};
        regs[addr]     = value;
        next_cycle();
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        next_cycle();
    endtask

    task automatic send_divide(input div_pkg::div_op_t op, input logic [2:0] rd,
                               input logic [2:0] rs1, input logic [2:0] rs2);
        logic [31:0] res;
        while (!issue_ready) begin
            next_cycle();
        end
        res               = model_result(op, regs[rs1], regs[rs2]);
        issue_new_request = 1'b1;
        issue_op          = op;
        issue_id          = next_id;
        issue_rs1_addr    = {2'b00, rs1};
        issue_rs2_addr    = {2'b00, rs2};
        issue_rd_addr     = {2'b00, rd};
        issue_rs1_data    = regs[rs1];
        issue_rs2_data    = regs[rs2];
        rd_issued         = 1'b1;
        rd_issued_addr    = {2'b00, rd};
        exp_push          = 1'b1;
        exp_op            = op;
        exp_id            = next_id;
        exp_result        = res;
        // The destination takes the result as soon as the divide issues
        regs[rd]          = res;
        next_id           = next_id + 1'b1;
        issued_count      = issued_count + 1;
        next_cycle();
    endtask

    //////////////////////////////
    // Clock, reset, ack and timeout
    //////////////////////////////
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Random ack on about half of the cycles with done high
    initial begin
        wb_ack    = 1'b0;
        ack_state = lcg_step(SEED ^ 32'hFFFF_0000);
        forever begin
            @(posedge clk);
            #1;
            ack_state = lcg_step(ack_state);
            wb_ack    = wb_done && ack_state[31];
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d results written back",
                     cycle_count, checked_count, issued_count);
            $display("Some tests failed");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        logic [31:0]      r;
        logic [31:0]      value;
        div_pkg::div_op_t op;
        rst               = 1'b1;
        issue_new_request = 1'b0;
        issue_op          = div_pkg::OP_DIV;
        issue_id          = '0;
        issue_rs1_addr    = '0;
        issue_rs2_addr    = '0;
        issue_rd_addr     = '0;
        issue_rs1_data    = '0;
        issue_rs2_data    = '0;
        rd_issued         = 1'b0;
        rd_issued_addr    = '0;
        flush             = 1'b0;
        exp_push          = 1'b0;
        exp_op            = div_pkg::OP_DIV;
        exp_id            = '0;
        exp_result        = '0;
        rand_state        = SEED;
        next_id           = '0;
        issued_count      = 0;
        cycle_count       = 0;
        for (int i = 0; i < 8; i++) begin
            random_value(regs[i]);
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Edge cases of overflow and zero divisor
        write_reg(3'd1, 32'h8000_0000);
        write_reg(3'd2, 32'hFFFF_FFFF);
        write_reg(3'd3, 32'h0);
        write_reg(3'd4, 32'd100);
        write_reg(3'd5, -32'd7);
        send_divide(div_pkg::OP_DIV, 3'd6, 3'd1, 3'd2);
        send_divide(div_pkg::OP_REM, 3'd7, 3'd1, 3'd2);
        send_divide(div_pkg::OP_DIVU, 3'd6, 3'd1, 3'd2);
        send_divide(div_pkg::OP_REMU, 3'd7, 3'd1, 3'd2);
        send_divide(div_pkg::OP_DIV, 3'd6, 3'd4, 3'd3);
        send_divide(div_pkg::OP_REM, 3'd7, 3'd4, 3'd3);
        send_divide(div_pkg::OP_DIVU, 3'd6, 3'd5, 3'd3);
        send_divide(div_pkg::OP_REMU, 3'd7, 3'd5, 3'd3);

        // DIV then REM on the same sources with and without disturbance
        send_divide(div_pkg::OP_DIV, 3'd6, 3'd4, 3'd5);
        send_divide(div_pkg::OP_REM, 3'd7, 3'd4, 3'd5);
        send_divide(div_pkg::OP_DIV, 3'd6, 3'd4, 3'd5);
        write_reg(3'd4, 32'd12345);
        send_divide(div_pkg::OP_REM, 3'd7, 3'd4, 3'd5);
        send_divide(div_pkg::OP_DIV, 3'd6, 3'd5, 3'd4);
        pulse_flush();
        send_divide(div_pkg::OP_REM, 3'd7, 3'd5, 3'd4);
        // Destination overwrites its own source, not one of the previous sources
        send_divide(div_pkg::OP_DIV, 3'd1, 3'd1, 3'd4);
        send_divide(div_pkg::OP_REM, 3'd7, 3'd1, 3'd4);

        while (issued_count < NUM_TESTS) begin
            draw(r);
            if (r[3:0] == 4'd0) begin
                random_value(value);
                write_reg(r[26:24], value);
            end
            if (r[7:4] == 4'd0) begin
                pulse_flush();
            end
            op = div_pkg::div_op_t'(r[9:8]);
            send_divide(op, r[18:16], r[12:10], r[15:13]);
            // Partner operation on the same sources
            if (r[21:19] < 3'd3 && issued_count < NUM_TESTS) begin
                send_divide(div_pkg::div_op_t'(r[9:8] ^ 2'b10), r[29:27], r[12:10], r[15:13]);
            end
            if (r[23:22] == 2'd0) begin
                next_cycle();
            end
        end

        while (checked_count < issued_count) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        $display("Checked %0d of %0d operations, %0d passed, %0d errors",
                 checked_count, issued_count, checked_count - error_count, error_count);
        if (error_count == 0 && checked_count == issued_count) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
source/div_pkg.sv
source/div_interfaces.sv
source/div_operand_prep.sv
source/div_control.sv
source/div_iter_counter.sv
source/div_datapath.sv
source/div_unit_top.sv
sim/div_checker.sv
sim/div_tb.sv

//--- Bender.yml
package:
  name: div_unit

sources:
  - source/div_pkg.sv
  - source/div_interfaces.sv
  - source/div_operand_prep.sv
  - source/div_control.sv
  - source/div_iter_counter.sv
  - source/div_datapath.sv
  - source/div_unit_top.sv
  - target: simulation
    files:
      - sim/div_checker.sv
      - sim/div_tb.sv
